//--- logic/coreSlice.sv
// top level of the execute slice: decode, ID/EX register and execute stage
`timescale 1ns/1ps
`include "cpuConsts.svh"

module coreSlice (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    input  logic [`DATA_WIDTH-1:0] pc,
    output logic                   resultValid,
    output logic [`REG_BITS-1:0]   resultReg,
    output logic [`DATA_WIDTH-1:0] resultData,
    output logic [`DATA_WIDTH-1:0] resultPc
);
    decodeBus    decBus();      // decode to ID/EX
    decodeBus    exBus();       // ID/EX to execute
    writeBackBus wbBus();

    decodeUnit decodeUnit_i (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wb         (wbBus.sink),
        .dec        (decBus.source)
    );

    regDE regDE_i (
        .clk   (clk),
        .reset (reset),
        .dIn   (decBus.sink),
        .dOut  (exBus.source)
    );

    executeUnit executeUnit_i (
        .clk   (clk),
        .reset (reset),
        .ex    (exBus.sink),
        .wb    (wbBus.source)
    );

    // result strobe is the register file write
    assign resultValid = wbBus.writeEnable;
    assign resultReg   = wbBus.writeTarget;
    assign resultData  = wbBus.writeData;
    assign resultPc    = wbBus.pc;

endmodule

//--- logic/cpuConsts.svh
// data path width, register file size, opcode and function code macros
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_WIDTH 32               // data path width
`define REG_COUNT  32               // architectural registers
`define REG_BITS   5                // register number width

// opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f

// function codes, R-type only
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_SLT 6'h2a

`endif

//--- logic/decodeUnit.sv
// decode unit: field split, ALU control, immediate extension, register file with bypass
`timescale 1ns/1ps
`include "cpuConsts.svh"

module decodeUnit
    import isaPkg::*, pipePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       instrValid,
    input  instr_t     instr,
    input  word_t      pc,
    writeBackBus.sink  wb,
    decodeBus.source   dec
);
    opcode_t opcode;
    funct_t  funct;
    regNum_t rsNum;
    regNum_t rtNum;
    regNum_t rdNum;
    shamt_t  shamt;
    imm16_t  imm;

    aluOp_t  aluOp;
    in2Sel_t in2Sel;
    word_t   extImm;
    regNum_t target;
    logic    known;             // opcode and funct both supported

    word_t regFile [`REG_COUNT];

    assign opcode = instr[31:26];
    assign rsNum  = instr[25:21];
    assign rtNum  = instr[20:16];
    assign rdNum  = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    always_comb begin
        aluOp  = ALU_ADD;
        in2Sel = IN2_REG;
        known  = 1'b1;
        target = rtNum;                                     // I-type writes rt
        extImm = {{(`DATA_WIDTH-16){1'b0}}, imm};           // zero extend by default
        case (opcode)
            `OP_RTYPE: begin
                target = rdNum;
                case (funct)
                    `FN_ADD: aluOp = ALU_ADD;
                    `FN_SUB: aluOp = ALU_SUB;
                    `FN_AND: aluOp = ALU_AND;
                    `FN_OR:  aluOp = ALU_OR;
                    `FN_XOR: aluOp = ALU_XOR;
                    `FN_SLT: aluOp = ALU_SLT;
                    `FN_SLL: aluOp = ALU_SLL;
                    `FN_SRL: aluOp = ALU_SRL;
                    default: known = 1'b0;
                endcase
            end
            `OP_ADDI: begin
                in2Sel = IN2_IMM;
                extImm = {{(`DATA_WIDTH-16){imm[15]}}, imm};    // only addi sign extends
            end
            `OP_ANDI: begin
                aluOp  = ALU_AND;
                in2Sel = IN2_IMM;
            end
            `OP_ORI: begin
                aluOp  = ALU_OR;
                in2Sel = IN2_IMM;
            end
            `OP_LUI: begin
                aluOp  = ALU_LUI;
                in2Sel = IN2_IMM;
            end
            default: known = 1'b0;
        endcase
    end

    // register file, r0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (wb.writeEnable && wb.writeTarget != '0) begin
            regFile[wb.writeTarget] <= wb.writeData;
        end
    end

    // same-cycle write-back wins over the stored value
    assign dec.rsData = (wb.writeEnable && rsNum != '0 && wb.writeTarget == rsNum)
                        ? wb.writeData : regFile[rsNum];
    assign dec.rtData = (wb.writeEnable && rtNum != '0 && wb.writeTarget == rtNum)
                        ? wb.writeData : regFile[rtNum];

    assign dec.valid         = instrValid;
    assign dec.pc            = pc;
    assign dec.rsNum         = rsNum;
    assign dec.rtNum         = rtNum;
    assign dec.imm32         = extImm;
    assign dec.shamt         = shamt;
    assign dec.aluIn2Sel     = in2Sel;
    assign dec.aluOp         = aluOp;
    assign dec.rfWriteEnable = known && target != '0;  // r0 writes dropped here
    assign dec.rfWriteTarget = target;

endmodule

//--- logic/executeUnit.sv
// operand forwarding, ALU and EX/WB result register of the execute stage
`timescale 1ns/1ps
`include "cpuConsts.svh"

module executeUnit
    import isaPkg::*, pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    decodeBus.sink      ex,
    writeBackBus.source wb
);
    // EX/WB result register
    logic    resWe;
    regNum_t resTarget;
    word_t   resData;
    word_t   resPc;

    word_t opA;
    word_t opB;
    word_t aluIn2;
    word_t aluOut;
    logic  sltBit;

    // previous instruction's result overrides the stale register read
    assign opA = (resWe && resTarget == ex.rsNum) ? resData : ex.rsData;
    assign opB = (resWe && resTarget == ex.rtNum) ? resData : ex.rtData;

    assign aluIn2 = (ex.aluIn2Sel == IN2_IMM) ? ex.imm32 : opB;
    assign sltBit = $signed(opA) < $signed(aluIn2);

    always_comb begin
        case (ex.aluOp)
            ALU_ADD: aluOut = opA + aluIn2;             // wraps
            ALU_SUB: aluOut = opA - aluIn2;
            ALU_AND: aluOut = opA & aluIn2;
            ALU_OR:  aluOut = opA | aluIn2;
            ALU_XOR: aluOut = opA ^ aluIn2;
            ALU_SLT: aluOut = {{(`DATA_WIDTH-1){1'b0}}, sltBit};
            ALU_SLL: aluOut = opB << ex.shamt;          // shifts take rt
            ALU_SRL: aluOut = opB >> ex.shamt;
            ALU_LUI: aluOut = {aluIn2[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    // strobe only for a valid instruction that writes
    always_ff @(posedge clk) begin
        if (reset) begin
            resWe <= 1'b0;
        end else begin
            resWe <= ex.valid && ex.rfWriteEnable;
        end
    end

    always_ff @(posedge clk) begin
        resTarget <= ex.rfWriteTarget;
        resData   <= aluOut;
        resPc     <= ex.pc;
    end

    assign wb.writeEnable = resWe;
    assign wb.writeTarget = resTarget;
    assign wb.writeData   = resData;
    assign wb.pc          = resPc;

endmodule

//--- logic/isaPkg.sv
// instruction set types: data and instruction words, register numbers, field widths
`include "cpuConsts.svh"

package isaPkg;

    // one data word on the integer path
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // raw instruction as fetched
    typedef logic [31:0] instr_t;

    // register file index, rs / rt / rd
    typedef logic [`REG_BITS-1:0] regNum_t;

    // shift amount field of sll and srl
    typedef logic [4:0] shamt_t;

    // top six bits of every instruction
    typedef logic [5:0] opcode_t;

    // low six bits of an R-type instruction
    typedef logic [5:0] funct_t;

    // raw immediate of an I-type instruction, before extension
    typedef logic [15:0] imm16_t;

    // field positions within instr_t
    //   opcode [31:26]  rs [25:21]  rt [20:16]
    //   rd [15:11]  shamt [10:6]  funct [5:0]
    //   imm [15:0]

endpackage

//--- logic/pipePkg.sv
// execute-stage controls: ALU operation and second-operand select
package pipePkg;

    // ALU operations, encoding picked so a bubble reads as add
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,         // signed compare
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8          // immediate into upper half
    } aluOp_t;

    // where the second ALU operand comes from
    typedef enum logic {
        IN2_REG = 1'b0,         // forwarded rt value
        IN2_IMM = 1'b1          // extended immediate
    } in2Sel_t;

    // R-type shifts take rt as the shifted value, so aluIn2Sel stays on
    // IN2_REG for them and shamt supplies the distance

endpackage

//--- logic/regDE.sv
// ID/EX pipeline register, cleared to a bubble when no valid instruction arrives
`timescale 1ns/1ps

module regDE
    import isaPkg::*, pipePkg::*;
(
    input  logic     clk,
    input  logic     reset,
    decodeBus.sink   dIn,
    decodeBus.source dOut
);
    logic    validQ;
    word_t   pcQ;
    regNum_t rsNumQ;
    word_t   rsDataQ;
    regNum_t rtNumQ;
    word_t   rtDataQ;
    word_t   imm32Q;
    shamt_t  shamtQ;
    in2Sel_t in2SelQ;
    aluOp_t  aluOpQ;
    logic    rfWeQ;
    regNum_t rfTargetQ;

    always_ff @(posedge clk) begin
        if (reset || !dIn.valid) begin          // bubble is all zeros
            validQ    <= 1'b0;
            pcQ       <= '0;
            rsNumQ    <= '0;
            rsDataQ   <= '0;
            rtNumQ    <= '0;
            rtDataQ   <= '0;
            imm32Q    <= '0;
            shamtQ    <= '0;
            in2SelQ   <= IN2_REG;
            aluOpQ    <= ALU_ADD;
            rfWeQ     <= 1'b0;
            rfTargetQ <= '0;
        end else begin
            validQ    <= 1'b1;
            pcQ       <= dIn.pc;
            rsNumQ    <= dIn.rsNum;
            rsDataQ   <= dIn.rsData;
            rtNumQ    <= dIn.rtNum;
            rtDataQ   <= dIn.rtData;
            imm32Q    <= dIn.imm32;
            shamtQ    <= dIn.shamt;
            in2SelQ   <= dIn.aluIn2Sel;
            aluOpQ    <= dIn.aluOp;
            rfWeQ     <= dIn.rfWriteEnable;
            rfTargetQ <= dIn.rfWriteTarget;
        end
    end

    assign dOut.valid         = validQ;
    assign dOut.pc            = pcQ;
    assign dOut.rsNum         = rsNumQ;
    assign dOut.rsData        = rsDataQ;
    assign dOut.rtNum         = rtNumQ;
    assign dOut.rtData        = rtDataQ;
    assign dOut.imm32         = imm32Q;
    assign dOut.shamt         = shamtQ;
    assign dOut.aluIn2Sel     = in2SelQ;
    assign dOut.aluOp         = aluOpQ;
    assign dOut.rfWriteEnable = rfWeQ;
    assign dOut.rfWriteTarget = rfTargetQ;

endmodule

//--- logic/stageBus.sv
// decodeBus and writeBackBus interfaces with source and sink modports
`timescale 1ns/1ps

interface decodeBus
    import isaPkg::*, pipePkg::*;
();
    logic    valid;             // instruction present, low for a bubble
    word_t   pc;
    regNum_t rsNum;
    word_t   rsData;
    regNum_t rtNum;
    word_t   rtData;
    word_t   imm32;             // already extended
    shamt_t  shamt;
    in2Sel_t aluIn2Sel;
    aluOp_t  aluOp;
    logic    rfWriteEnable;
    regNum_t rfWriteTarget;

    modport source(output valid, pc, rsNum, rsData, rtNum, rtData, imm32, shamt,
                   aluIn2Sel, aluOp, rfWriteEnable, rfWriteTarget);
    modport sink(input valid, pc, rsNum, rsData, rtNum, rtData, imm32, shamt,
                 aluIn2Sel, aluOp, rfWriteEnable, rfWriteTarget);
endinterface

interface writeBackBus
    import isaPkg::*;
();
    logic    writeEnable;       // high for one cycle per result
    regNum_t writeTarget;
    word_t   writeData;
    word_t   pc;                // pc of the producing instruction

    modport source(output writeEnable, writeTarget, writeData, pc);
    modport sink(input writeEnable, writeTarget, writeData, pc);
endinterface

//--- runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir
rm -f build.log sim.log
verilator --binary --timing -f src.f --top-module coreSliceTb -o coreSliceSim > build.log 2>&1 \
    && ./obj_dir/coreSliceSim > sim.log 2>&1 \
    || { echo "build or simulation reported a problem"; cat build.log sim.log 2>/dev/null; }
grep -q "^Done: no errors$" sim.log 2>/dev/null \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

//--- src.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageBus.sv
logic/decodeUnit.sv
logic/regDE.sv
logic/executeUnit.sv
logic/coreSlice.sv
verif/coreSliceTb.sv

//--- verif/coreSliceTb.sv
// clock, reset, random instruction stream, reference model and checks for coreSlice
`timescale 1ns/1ps
`include "cpuConsts.svh"

module coreSliceTb
    import isaPkg::*;
();
    localparam int RESET_CYCLES = 8;
    localparam int NUM_SLOTS    = 400;             // issue slots including idle ones
    localparam int DRIVE_DELAY  = 2;
    localparam int TIMEOUT_NS   = RESET_CYCLES * 20 + NUM_SLOTS * 40;

    logic    clk;
    logic    reset;
    logic    instrValid;
    instr_t  instr;
    word_t   pc;
    logic    resultValid;
    regNum_t resultReg;
    word_t   resultData;
    word_t   resultPc;

    integer seed = 32'h400;
    int     cycleCount = 0;                        // rising edges seen so far
    word_t  modelRegs [`REG_COUNT];

    // pending results in issue order
    regNum_t expReg[$];
    word_t   expData[$];
    word_t   expPc[$];
    int      expCycle[$];

    coreSlice coreSlice_i (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .resultValid (resultValid),
        .resultReg   (resultReg),
        .resultData  (resultData),
        .resultPc    (resultPc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on a failure");
    endtask

    task automatic checkValue(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
            stopWithFailure();
        end
    endtask

    // reference model executes at issue and queues what the DUT must write back
    task automatic issueInstr(input instr_t ins, input word_t pcVal);
        opcode_t op;
        funct_t  fn;
        regNum_t rs;
        regNum_t rt;
        regNum_t dst;
        shamt_t  sh;
        word_t   a;
        word_t   b;
        word_t   immS;
        word_t   immZ;
        word_t   res;
        logic    writes;
        op     = ins[31:26];
        rs     = ins[25:21];
        rt     = ins[20:16];
        sh     = ins[10:6];
        fn     = ins[5:0];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        immS   = {{16{ins[15]}}, ins[15:0]};
        immZ   = {16'h0000, ins[15:0]};
        dst    = rt;                               // I-type target
        res    = '0;
        writes = 1'b1;
        case (op)
            `OP_RTYPE: begin
                dst = ins[15:11];
                case (fn)
                    `FN_ADD: res = a + b;
                    `FN_SUB: res = a - b;
                    `FN_AND: res = a & b;
                    `FN_OR:  res = a | b;
                    `FN_XOR: res = a ^ b;
                    `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL: res = b << sh;
                    `FN_SRL: res = b >> sh;
                    default: writes = 1'b0;
                endcase
            end
            `OP_ADDI: res = a + immS;
            `OP_ANDI: res = a & immZ;
            `OP_ORI:  res = a | immZ;
            `OP_LUI:  res = {ins[15:0], 16'h0000};
            default:  writes = 1'b0;
        endcase
        if (dst == '0) begin
            writes = 1'b0;                         // r0 stays zero
        end
        if (writes) begin
            modelRegs[dst] = res;
            expReg.push_back(dst);
            expData.push_back(res);
            expPc.push_back(pcVal);
            expCycle.push_back(cycleCount + 2);    // fixed two-cycle latency
        end
    endtask

    function automatic instr_t randomInstr();
        logic [31:0] r;
        logic [3:0]  pick;
        regNum_t     rs;
        regNum_t     rt;
        regNum_t     rd;
        shamt_t      sh;
        funct_t      fn;
        opcode_t     op;
        r    = $random(seed);
        pick = r[31:28];
        rs   = regNum_t'(r[2:0]);                  // r0..r7 keeps dependencies dense
        rt   = regNum_t'(r[5:3]);
        rd   = regNum_t'(r[8:6]);
        sh   = r[13:9];
        case (pick)
            4'd0:    fn = `FN_ADD;
            4'd1:    fn = `FN_SUB;
            4'd2:    fn = `FN_AND;
            4'd3:    fn = `FN_OR;
            4'd4:    fn = `FN_XOR;
            4'd5:    fn = `FN_SLT;
            4'd6:    fn = `FN_SLL;
            4'd7:    fn = `FN_SRL;
            default: fn = 6'h3f;                   // unknown function code
        endcase
        case (pick)
            4'd8, 4'd14:  op = `OP_ADDI;
            4'd9:         op = `OP_ANDI;
            4'd10, 4'd15: op = `OP_ORI;
            4'd11:        op = `OP_LUI;
            4'd12:        op = 6'h3f;              // unknown opcode
            default:      op = `OP_RTYPE;
        endcase
        if (op == `OP_RTYPE) begin
            randomInstr = {op, rs, rt, rd, sh, fn};
        end else begin
            randomInstr = {op, rs, rt, r[27:12]};
        end
    endfunction

    // result checks at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (resultValid === 1'b1) begin
                if (expReg.size() == 0) begin
                    $display("unexpected result r%0d = %h from pc %h, nothing was pending",
                             resultReg, resultData, resultPc);
                    stopWithFailure();
                end else begin
                    checkValue(word_t'(cycleCount), word_t'(expCycle[0]), "result cycle");
                    checkValue(resultPc, expPc[0], "result pc");
                    checkValue(word_t'(resultReg), word_t'(expReg[0]), "result register");
                    checkValue(resultData, expData[0], "result data");
                    void'(expReg.pop_front());
                    void'(expData.pop_front());
                    void'(expPc.pop_front());
                    void'(expCycle.pop_front());
                end
            end else if (resultValid !== 1'b0) begin
                $display("resultValid is unknown after reset");
                stopWithFailure();
            end else if (expCycle.size() != 0 && cycleCount >= expCycle[0]) begin
                $display("the result of the instruction at pc %h never appeared", expPc[0]);
                stopWithFailure();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the instruction stream finished");
        stopWithFailure();
    end

    initial begin
        instr_t      ins;
        logic [31:0] dice;
        word_t       nextPc;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        nextPc     = 32'h0000_1000;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;
        for (int slot = 0; slot < NUM_SLOTS; slot++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            dice  = $random(seed);
            ins   = randomInstr();
            instr = ins;                           // junk word on idle slots too
            if (dice[2:0] == 3'd0) begin
                instrValid = 1'b0;                 // bubble
            end else begin
                instrValid = 1'b1;
                pc         = nextPc;
                issueInstr(ins, nextPc);
                nextPc     = nextPc + 32'd4;
            end
        end
        @(posedge clk);
        #DRIVE_DELAY instrValid = 1'b0;
        repeat (3) @(posedge clk);                 // drain the two pipeline stages
        #DRIVE_DELAY;
        if (expReg.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d expected results are still pending at the end", expReg.size());
            stopWithFailure();
        end
    end

endmodule
